// File: dv/rob_tb.sv
// reorder buffer testbench
module rob_tb
	import rob_pkg::*;
();

	localparam int fill_cycles = 20; // cycles per thread to reach full
	localparam int random_cycles = 600;
	localparam int drain_bound = 2 * rob_depth;
	localparam int stimulus_cycles = 2 * fill_cycles + random_cycles + 2 * drain_bound;
	localparam int timeout_cycles = stimulus_cycles + 200;
	localparam int report_width = $bits(commit_t);

	typedef commit_t [1:0] commit_pair_t;

	// reference model entry
	typedef struct packed {
		dispatch_inst_t inst;
		logic done;
		logic mispredict;
		logic [pc_width-1:0] target_pc;
	} model_entry_t;

	logic clock;
	logic reset;
	logic is_thread1;
	logic dispatch_load;
	dispatch_inst_t [1:0] dispatch;
	complete_t [1:0] complete;
	rob_tag_t [1:0] dispatch_tag;
	commit_t [1:0] commit;
	logic t1_full;
	logic t2_full;

	model_entry_t rob_q [2][$]; // index 0 is thread 1
	rob_idx_t head_idx [2];
	int cycle_count;

	tb_clock_gen clock_gen (
		.clock(clock),
		.reset(reset)
	);

	rob_top dut (
		.clock(clock),
		.reset(reset),
		.is_thread1(is_thread1),
		.dispatch_load(dispatch_load),
		.dispatch(dispatch),
		.complete(complete),
		.dispatch_tag(dispatch_tag),
		.commit(commit),
		.t1_full(t1_full),
		.t2_full(t2_full)
	);

	task automatic report_mismatch(input string name, input logic [report_width-1:0] expected,
		input logic [report_width-1:0] actual);
		$display("ERROR %s expected %h got %h", name, expected, actual);
		$display("Done: errors found");
		$fatal(1, "stopped at the first mismatch");
	endtask

	function automatic logic entry_ready(int t, int k);
		return (rob_q[t].size() > k) && rob_q[t][k].done;
	endfunction

	function automatic logic is_redirect(int t, int k);
		return rob_q[t][k].inst.is_branch & rob_q[t][k].mispredict;
	endfunction

	function automatic commit_t entry_commit(int t, int k);
		model_entry_t e;
		commit_t c;
		e = rob_q[t][k];
		c.valid = 1'b1;
		c.is_thread1 = (t == 0);
		c.pc = e.inst.pc;
		c.target_pc = e.target_pc;
		c.is_branch = e.inst.is_branch;
		c.mispredict = e.mispredict;
		c.arn_dest = e.inst.arn_dest;
		c.prn_dest = e.inst.prn_dest;
		return c;
	endfunction

	// thread 1 head goes first and slot 1 stops behind a mispredicted branch
	function automatic commit_pair_t expected_commit();
		commit_pair_t pair;
		pair = '0;
		if (entry_ready(0, 0))
		begin
			pair[0] = entry_commit(0, 0);
			if (entry_ready(0, 1) && !is_redirect(0, 0))
				pair[1] = entry_commit(0, 1);
			else if (entry_ready(1, 0))
				pair[1] = entry_commit(1, 0);
		end
		else if (entry_ready(1, 0))
		begin
			pair[0] = entry_commit(1, 0);
			if (entry_ready(1, 1) && !is_redirect(1, 0))
				pair[1] = entry_commit(1, 1);
		end
		return pair;
	endfunction

	// compare at mid-cycle, then step the model over the next edge
	task automatic check_and_update();
		commit_pair_t exp;
		logic exp_full [2];
		rob_tag_t exp_tag;
		int retire [2];
		logic flush [2];
		logic flushing;
		int t;
		int k;
		model_entry_t e;
		exp = expected_commit();
		for (int s = 0; s < 2; s++)
		begin
			assert (commit[s].valid === exp[s].valid)
				else report_mismatch($sformatf("commit[%0d].valid", s),
					report_width'(exp[s].valid), report_width'(commit[s].valid));
			if (exp[s].valid)
				assert (commit[s] === exp[s])
					else report_mismatch($sformatf("commit[%0d]", s), exp[s], commit[s]);
		end
		exp_full[0] = rob_q[0].size() >= 15;
		exp_full[1] = rob_q[1].size() >= 15;
		assert (t1_full === exp_full[0])
			else report_mismatch("t1_full", report_width'(exp_full[0]), report_width'(t1_full));
		assert (t2_full === exp_full[1])
			else report_mismatch("t2_full", report_width'(exp_full[1]), report_width'(t2_full));
		if (dispatch_load)
		begin
			t = is_thread1 ? 0 : 1;
			for (int s = 0; s < 2; s++)
			begin
				exp_tag.is_thread2 = ~is_thread1;
				exp_tag.idx = head_idx[t] + rob_idx_t'(rob_q[t].size() + s); // tail, tail + 1
				assert (dispatch_tag[s] === exp_tag)
					else report_mismatch($sformatf("dispatch_tag[%0d]", s),
						report_width'(exp_tag), report_width'(dispatch_tag[s]));
			end
		end
		retire[0] = 0;
		retire[1] = 0;
		flush[0] = 1'b0;
		flush[1] = 1'b0;
		for (int s = 0; s < 2; s++)
		begin
			if (exp[s].valid)
			begin
				t = exp[s].is_thread1 ? 0 : 1;
				retire[t]++;
				if (exp[s].is_branch && exp[s].mispredict)
					flush[t] = 1'b1;
			end
		end
		for (int tt = 0; tt < 2; tt++)
		begin
			repeat (retire[tt]) void'(rob_q[tt].pop_front());
			head_idx[tt] = head_idx[tt] + rob_idx_t'(retire[tt]);
			if (flush[tt])
				rob_q[tt].delete(); // everything left is younger
		end
		flushing = flush[0] | flush[1];
		for (int p = 0; p < 2; p++)
		begin
			if (complete[p].valid)
			begin
				t = complete[p].tag.is_thread2 ? 1 : 0;
				k = int'(rob_idx_t'(complete[p].tag.idx - head_idx[t]));
				if (k < rob_q[t].size())
				begin
					e = rob_q[t][k];
					e.done = 1'b1;
					e.mispredict = complete[p].mispredict;
					e.target_pc = complete[p].target_pc;
					rob_q[t][k] = e;
				end
			end
		end
		if (dispatch_load && !flushing)
		begin
			t = is_thread1 ? 0 : 1;
			for (int s = 0; s < 2; s++)
			begin
				e.inst = dispatch[s];
				e.done = 1'b0;
				e.mispredict = 1'b0;
				e.target_pc = '0;
				rob_q[t].push_back(e);
			end
		end
	endtask

	// thread_sel 0 is thread 1, 1 is thread 2, 2 picks at random
	task automatic drive_cycle(input int dispatch_pct, input int thread_sel,
		input int complete_pct, input int mispredict_pct);
		logic thread1;
		int t;
		int pick;
		rob_tag_t tag;
		rob_tag_t open_tags[$];
		dispatch_inst_t [1:0] pair;
		complete_t [1:0] comp;
		if (thread_sel == 2)
			thread1 = ($urandom_range(0, 1) == 1);
		else
			thread1 = (thread_sel == 0);
		t = thread1 ? 0 : 1;
		for (int s = 0; s < 2; s++)
		begin
			pair[s].pc = {$urandom, $urandom};
			pair[s].arn_dest = arf_width'($urandom);
			pair[s].prn_dest = prf_width'($urandom);
			pair[s].is_branch = ($urandom_range(0, 2) == 0);
		end
		for (int tt = 0; tt < 2; tt++)
		begin
			for (int k = 0; k < rob_q[tt].size(); k++)
			begin
				if (!rob_q[tt][k].done)
				begin
					tag.is_thread2 = (tt == 1);
					tag.idx = head_idx[tt] + rob_idx_t'(k);
					open_tags.push_back(tag);
				end
			end
		end
		comp = '0;
		for (int p = 0; p < 2; p++)
		begin
			if (open_tags.size() > 0 && $urandom_range(0, 99) < complete_pct)
			begin
				pick = $urandom_range(0, open_tags.size() - 1); // any open entry of either thread
				comp[p].valid = 1'b1;
				comp[p].tag = open_tags[pick];
				comp[p].mispredict = ($urandom_range(0, 99) < mispredict_pct);
				comp[p].target_pc = {$urandom, $urandom};
				open_tags.delete(pick);
			end
		end
		is_thread1 <= thread1;
		dispatch <= pair;
		dispatch_load <= ($urandom_range(0, 99) < dispatch_pct) && (rob_q[t].size() < 15);
		complete <= comp;
		@(posedge clock);
	endtask

	task automatic drain();
		while (rob_q[0].size() + rob_q[1].size() != 0)
			drive_cycle(0, 2, 100, 0);
	endtask

	initial
	begin
		void'($urandom(87195));
		is_thread1 <= 1'b0;
		dispatch_load <= 1'b0;
		dispatch <= '0;
		complete <= '0;
		do
			@(posedge clock);
		while (reset);
		repeat (fill_cycles) drive_cycle(100, 0, 0, 0); // thread 1 runs into full
		repeat (fill_cycles) drive_cycle(100, 1, 0, 0);
		drain();
		repeat (random_cycles) drive_cycle(70, 2, 80, 10);
		drain();
		repeat (2) @(posedge clock);
		$display("Done: no errors");
		$finish;
	end

	initial
	begin
		head_idx[0] = '0;
		head_idx[1] = '0;
		forever
		begin
			@(negedge clock);
			if (!reset)
				check_and_update();
		end
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clock);
			cycle_count++;
		end
		$display("timeout: the run did not finish within %0d cycles", timeout_cycles);
		$display("Done: errors found");
		$fatal(1, "timeout");
	end

endmodule

// File: dv/tb_clock_gen.sv
// testbench clock and reset
module tb_clock_gen (
	output logic clock,
	output logic reset
);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock; // period 20
	end

	initial
	begin
		reset = 1'b1;
		repeat (2) @(posedge clock);
		reset <= 1'b0;
	end

endmodule

// File: files.f
logic/rob_pkg.sv
logic/rob_thread_queue.sv
logic/rob_tag_router.sv
logic/rob_commit_select.sv
logic/rob_top.sv
dv/tb_clock_gen.sv
dv/rob_tb.sv

// File: logic/rob_commit_select.sv
// two-wide in-order commit selection
module rob_commit_select
	import rob_pkg::*;
(
	input head_view_t [1:0] t1_head_pair,
	input head_view_t [1:0] t2_head_pair,
	output commit_t [1:0] commit,
	output logic [1:0] t1_retire,
	output logic [1:0] t2_retire,
	output logic t1_flush,
	output logic t2_flush,
	output logic flush_any
);

	logic t1_redirect; // thread 1 head is a mispredicted branch
	logic t2_redirect;

	function automatic commit_t to_commit(head_view_t h, logic thread1);
		commit_t c;
		c.valid = 1'b1;
		c.is_thread1 = thread1;
		c.pc = h.pc;
		c.target_pc = h.target_pc;
		c.is_branch = h.is_branch;
		c.mispredict = h.mispredict;
		c.arn_dest = h.arn_dest;
		c.prn_dest = h.prn_dest;
		return c;
	endfunction

	function automatic logic redirects(commit_t c);
		return c.valid & c.is_branch & c.mispredict;
	endfunction

	assign t1_redirect = t1_head_pair[0].is_branch & t1_head_pair[0].mispredict;
	assign t2_redirect = t2_head_pair[0].is_branch & t2_head_pair[0].mispredict;

	// thread 1 has priority for slot 0
	always_comb
	begin
		commit = '0;
		t1_retire = 2'd0;
		t2_retire = 2'd0;
		if (t1_head_pair[0].ready)
		begin
			commit[0] = to_commit(t1_head_pair[0], 1'b1);
			t1_retire = 2'd1;
			if (t1_head_pair[1].ready && !t1_redirect)
			begin
				commit[1] = to_commit(t1_head_pair[1], 1'b1);
				t1_retire = 2'd2;
			end
			else if (t2_head_pair[0].ready)
			begin
				commit[1] = to_commit(t2_head_pair[0], 1'b0);
				t2_retire = 2'd1;
			end
		end
		else if (t2_head_pair[0].ready)
		begin
			commit[0] = to_commit(t2_head_pair[0], 1'b0);
			t2_retire = 2'd1;
			if (t2_head_pair[1].ready && !t2_redirect)
			begin
				commit[1] = to_commit(t2_head_pair[1], 1'b0);
				t2_retire = 2'd2;
			end
		end
	end

	// the mispredicted branch is always the last commit of its thread
	always_comb
	begin
		t1_flush = 1'b0;
		t2_flush = 1'b0;
		for (int s = 0; s < 2; s++)
		begin
			if (redirects(commit[s]) && commit[s].is_thread1)
				t1_flush = 1'b1;
			if (redirects(commit[s]) && !commit[s].is_thread1)
				t2_flush = 1'b1;
		end
	end

	assign flush_any = t1_flush | t2_flush;

endmodule

// File: logic/rob_pkg.sv
// reorder buffer definitions
package rob_pkg;

	localparam int rob_depth = 16; // entries per thread
	localparam int rob_idx_width = $clog2(rob_depth);
	localparam int arf_width = 5;
	localparam int prf_width = 6; // 64-entry prf
	localparam int pc_width = 64;

	typedef logic [rob_idx_width-1:0] rob_idx_t;

	// tag as handed to the reservation stations
	typedef struct packed {
		logic is_thread2; // 0 selects thread 1
		rob_idx_t idx;
	} rob_tag_t;

	typedef struct packed {
		logic [pc_width-1:0] pc;
		logic [arf_width-1:0] arn_dest;
		logic [prf_width-1:0] prn_dest;
		logic is_branch;
	} dispatch_inst_t;

	// completion as it leaves a functional unit
	typedef struct packed {
		logic valid;
		rob_tag_t tag;
		logic mispredict;
		logic [pc_width-1:0] target_pc;
	} complete_t;

	// same completion after the thread bit has been decoded
	typedef struct packed {
		logic valid;
		rob_idx_t idx;
		logic mispredict;
		logic [pc_width-1:0] target_pc;
	} thread_complete_t;

	typedef struct packed {
		logic ready; // occupied and done
		logic [pc_width-1:0] pc;
		logic [pc_width-1:0] target_pc;
		logic is_branch;
		logic mispredict;
		logic [arf_width-1:0] arn_dest;
		logic [prf_width-1:0] prn_dest;
	} head_view_t;

	typedef struct packed {
		logic valid;
		logic is_thread1;
		logic [pc_width-1:0] pc;
		logic [pc_width-1:0] target_pc;
		logic is_branch;
		logic mispredict;
		logic [arf_width-1:0] arn_dest;
		logic [prf_width-1:0] prn_dest;
	} commit_t;

endpackage

// File: logic/rob_tag_router.sv
// dispatch and completion routing
module rob_tag_router
	import rob_pkg::*;
(
	input logic is_thread1,
	input logic dispatch_load,
	input logic flush_any,
	input rob_idx_t t1_tail,
	input rob_idx_t t2_tail,
	input complete_t [1:0] complete,
	output logic t1_load,
	output logic t2_load,
	output rob_tag_t [1:0] dispatch_tag,
	output thread_complete_t [1:0] t1_complete,
	output thread_complete_t [1:0] t2_complete
);

	rob_idx_t base;

	// a pair arriving during a flush is dropped
	assign t1_load = dispatch_load & is_thread1 & ~flush_any;
	assign t2_load = dispatch_load & ~is_thread1 & ~flush_any;

	assign base = is_thread1 ? t1_tail : t2_tail;
	assign dispatch_tag[0] = '{is_thread2: ~is_thread1, idx: base};
	assign dispatch_tag[1] = '{is_thread2: ~is_thread1, idx: base + 1'b1};

	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			t1_complete[i].valid = complete[i].valid & ~complete[i].tag.is_thread2;
			t2_complete[i].valid = complete[i].valid & complete[i].tag.is_thread2;
			t1_complete[i].idx = complete[i].tag.idx; // thread-local index
			t2_complete[i].idx = complete[i].tag.idx;
			t1_complete[i].mispredict = complete[i].mispredict;
			t2_complete[i].mispredict = complete[i].mispredict;
			t1_complete[i].target_pc = complete[i].target_pc;
			t2_complete[i].target_pc = complete[i].target_pc;
		end
	end

	// both ports naming one entry would make the stored result ambiguous
	always_comb
	begin
		distinct_completions: assert final (!(complete[0].valid && complete[1].valid
			&& complete[0].tag == complete[1].tag))
			else $error("both completion ports carry tag %h", complete[0].tag);
	end

endmodule

// File: logic/rob_thread_queue.sv
// per-thread rob storage
module rob_thread_queue
	import rob_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic load,
	input dispatch_inst_t [1:0] dispatch,
	input thread_complete_t [1:0] complete,
	input logic [1:0] retire_count,
	input logic flush,
	output head_view_t [1:0] head_pair,
	output rob_idx_t tail,
	output logic full
);

	rob_idx_t head;
	rob_idx_t next_head;
	rob_idx_t tail_next; // second slot of a dispatch pair
	rob_idx_t [1:0] view_idx;
	logic [rob_idx_width:0] count; // occupied entries from 0 to rob_depth
	logic [rob_idx_width:0] next_count;

	logic [rob_depth-1:0] occupied;
	logic [rob_depth-1:0] done;
	dispatch_inst_t entries [rob_depth];
	logic mispredict [rob_depth];
	logic [pc_width-1:0] target_pc [rob_depth];

	assign view_idx[0] = head;
	assign view_idx[1] = head + 1'b1; // wraps at the depth
	assign tail_next = tail + 1'b1;
	assign next_head = head + rob_idx_t'(retire_count);

	always_comb
	begin
		next_count = count - {{(rob_idx_width - 1){1'b0}}, retire_count};
		if (load)
			next_count = next_count + 2'd2;
	end

	// a pair needs two free slots, so 15 occupied already counts as full
	assign full = count[rob_idx_width] | (&count[rob_idx_width-1:0]);

	always_comb
	begin
		for (int k = 0; k < 2; k++)
		begin
			head_pair[k].ready = occupied[view_idx[k]] & done[view_idx[k]];
			head_pair[k].pc = entries[view_idx[k]].pc;
			head_pair[k].target_pc = target_pc[view_idx[k]];
			head_pair[k].is_branch = entries[view_idx[k]].is_branch;
			head_pair[k].mispredict = mispredict[view_idx[k]];
			head_pair[k].arn_dest = entries[view_idx[k]].arn_dest;
			head_pair[k].prn_dest = entries[view_idx[k]].prn_dest;
		end
	end

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			head <= '0;
			tail <= '0;
			count <= '0;
			occupied <= '0;
			done <= '0;
		end
		else
		begin
			for (int i = 0; i < 2; i++)
			begin
				if (complete[i].valid)
					done[complete[i].idx] <= 1'b1;
			end
			if (retire_count != 2'd0)
				occupied[view_idx[0]] <= 1'b0;
			if (retire_count == 2'd2)
				occupied[view_idx[1]] <= 1'b0;
			if (flush)
			begin
				// nothing younger than the branch survives
				occupied <= '0;
				tail <= next_head;
				count <= '0;
			end
			else
			begin
				if (load)
				begin
					occupied[tail] <= 1'b1;
					occupied[tail_next] <= 1'b1;
					done[tail] <= 1'b0; // load wins over a stale completion
					done[tail_next] <= 1'b0;
					tail <= tail + 2'd2;
				end
				count <= next_count;
			end
			head <= next_head;
		end
	end

	// payload and completion results
	always_ff @(posedge clock)
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (complete[i].valid)
			begin
				mispredict[complete[i].idx] <= complete[i].mispredict;
				target_pc[complete[i].idx] <= complete[i].target_pc;
			end
		end
		if (load)
		begin
			entries[tail] <= dispatch[0];
			entries[tail_next] <= dispatch[1];
		end
	end

	no_load_when_full: assert property (@(posedge clock) disable iff (reset) load |-> !full)
		else $error("dispatch pair loaded into a full thread");

	retire_within_ready: assert property (@(posedge clock) disable iff (reset)
		retire_count <= (head_pair[0].ready ? (head_pair[1].ready ? 2'd2 : 2'd1) : 2'd0))
		else $error("retire of an entry that is not ready");

endmodule

// File: logic/rob_top.sv
// two-thread reorder buffer
module rob_top
	import rob_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic is_thread1,
	input logic dispatch_load,
	input dispatch_inst_t [1:0] dispatch, // slot 0 is older
	input complete_t [1:0] complete,
	output rob_tag_t [1:0] dispatch_tag,
	output commit_t [1:0] commit, // slot 0 is older
	output logic t1_full,
	output logic t2_full
);

	logic t1_load;
	logic t2_load;
	logic flush_any;
	logic t1_flush;
	logic t2_flush;
	logic [1:0] t1_retire;
	logic [1:0] t2_retire;
	rob_idx_t t1_tail;
	rob_idx_t t2_tail;
	thread_complete_t [1:0] t1_complete;
	thread_complete_t [1:0] t2_complete;
	head_view_t [1:0] t1_head_pair;
	head_view_t [1:0] t2_head_pair;

	rob_tag_router router (
		.is_thread1(is_thread1),
		.dispatch_load(dispatch_load),
		.flush_any(flush_any),
		.t1_tail(t1_tail),
		.t2_tail(t2_tail),
		.complete(complete),
		.t1_load(t1_load),
		.t2_load(t2_load),
		.dispatch_tag(dispatch_tag),
		.t1_complete(t1_complete),
		.t2_complete(t2_complete)
	);

	rob_thread_queue t1_queue (
		.clock(clock),
		.reset(reset),
		.load(t1_load),
		.dispatch(dispatch),
		.complete(t1_complete),
		.retire_count(t1_retire),
		.flush(t1_flush),
		.head_pair(t1_head_pair),
		.tail(t1_tail),
		.full(t1_full)
	);

	rob_thread_queue t2_queue (
		.clock(clock),
		.reset(reset),
		.load(t2_load),
		.dispatch(dispatch),
		.complete(t2_complete),
		.retire_count(t2_retire),
		.flush(t2_flush),
		.head_pair(t2_head_pair),
		.tail(t2_tail),
		.full(t2_full)
	);

	rob_commit_select select (
		.t1_head_pair(t1_head_pair),
		.t2_head_pair(t2_head_pair),
		.commit(commit),
		.t1_retire(t1_retire),
		.t2_retire(t2_retire),
		.t1_flush(t1_flush),
		.t2_flush(t2_flush),
		.flush_any(flush_any)
	);

endmodule
